//--- Bender.yml
package:
  name: dot_tile

export_include_dirs:
  - common

sources:
  - common/tile_axi_pkg.sv
  - common/tile_dot_pkg.sv
  - rtl/tile_fetch.sv
  - rtl/tile_mac.sv
  - rtl/tile_writeback.sv
  - rtl/dot_tile.sv
  - target: simulation
    files:
      - sim/tile_vip.sv
      - sim/tb_dot_tile.sv

//--- common/tile_axi_pkg.sv
/*
  AXI4-Lite types shared by the tile stages.
  No IDs, no bursts, no user signals. EXOKAY is not expected on AXI4-Lite,
  so any response other than OKAY is treated as an error.
*/
`include "tile_config.svh"

package tile_axi_pkg;

  // One bus word of address or data
  typedef logic [`TILE_ADDR_W-1:0]   addr_t;
  typedef logic [`TILE_DATA_W-1:0]   data_t;
  typedef logic [`TILE_DATA_W/8-1:0] strb_t;  // One bit per byte lane

  // Response codes as on the bus
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Error check used on both the r and b channels
  function automatic logic resp_is_err(input resp_e resp);
    return resp != OKAY;
  endfunction

endpackage

//--- common/tile_config.svh
/*
  Shared widths and end-of-computation constants for the dot-product tile.
  Only 32-bit address and data are supported, since an operand word packs
  exactly two 16-bit values and the bus has a single 4-byte strobe.
*/
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// Bus widths
`define TILE_ADDR_W 32
`define TILE_DATA_W 32

// Exit code lands here once the job is finished
`define TILE_EOC_ADDR 32'h2C03_0000

// Exit codes written to the EOC word
`define TILE_EXIT_OK  32'd1  // Every response was OKAY
`define TILE_EXIT_ERR 32'd2  // At least one read or write error

`endif

//--- common/tile_dot_pkg.sv
/*
  Datapath types of the dot-product tile.
  Operand words hold op_a in the upper half and op_b in the lower half,
  both two's complement. The accumulator wraps at 32 bits.
*/
`include "tile_config.svh"

package tile_dot_pkg;

  // One bus word, seen either raw (length, exit code) or as an operand pair
  typedef union packed {
    tile_axi_pkg::data_t raw;
    struct packed {
      logic signed [`TILE_DATA_W/2-1:0] op_a;  // Upper half
      logic signed [`TILE_DATA_W/2-1:0] op_b;  // Lower half
    } pair;
  } operand_u;

  // Running sum and final result
  typedef logic signed [`TILE_DATA_W-1:0] acc_t;

endpackage

//--- rtl/dot_tile.sv
/*
  Dot-product tile top. A rising edge on fetch_enable_i while idle starts
  one job at boot_addr_i. Single AXI4-Lite master, one transaction in flight
  per channel pair. The read channels belong to fetch, the write channels
  to writeback.
*/
`timescale 1ns/10ps

module dot_tile (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                fetch_enable_i,
  input  tile_axi_pkg::addr_t boot_addr_i,
  output logic                aw_valid_o,
  input  logic                aw_ready_i,
  output tile_axi_pkg::addr_t aw_addr_o,
  output logic                w_valid_o,
  input  logic                w_ready_i,
  output tile_axi_pkg::data_t w_data_o,
  output tile_axi_pkg::strb_t w_strb_o,
  input  logic                b_valid_i,
  output logic                b_ready_o,
  input  tile_axi_pkg::resp_e b_resp_i,
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  output tile_axi_pkg::addr_t ar_addr_o,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  input  tile_axi_pkg::data_t r_data_i,
  input  tile_axi_pkg::resp_e r_resp_i,
  output logic                busy_o
);

  logic                   fe_q;
  logic                   start;
  logic                   op_valid;
  logic                   op_ready;
  tile_dot_pkg::operand_u op_data;
  logic                   op_last;
  tile_axi_pkg::addr_t    op_res_addr;
  logic                   op_rd_err;
  logic                   res_valid;
  logic                   res_ready;
  tile_dot_pkg::acc_t     res_data;
  tile_axi_pkg::addr_t    res_addr;
  logic                   res_rd_err;

  // Start on a fetch_enable edge, ignored mid-job
  always_ff @(posedge clk) begin
    if (rst_i) fe_q <= 1'b0;
    else fe_q <= fetch_enable_i;
  end
  assign start = fetch_enable_i && !fe_q && !busy_o;

  tile_fetch fetch_i (
    .clk, .rst_i, .start_i(start), .base_addr_i(boot_addr_i),
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .r_valid_i, .r_ready_o, .r_data_i, .r_resp_i,
    .op_valid_o(op_valid), .op_ready_i(op_ready), .op_data_o(op_data),
    .op_last_o(op_last), .res_addr_o(op_res_addr), .rd_err_o(op_rd_err)
  );

  tile_mac mac_i (
    .clk, .rst_i, .op_valid_i(op_valid), .op_ready_o(op_ready), .op_data_i(op_data),
    .op_last_i(op_last), .res_addr_i(op_res_addr), .rd_err_i(op_rd_err),
    .res_valid_o(res_valid), .res_ready_i(res_ready), .res_data_o(res_data),
    .res_addr_o(res_addr), .rd_err_o(res_rd_err)
  );

  tile_writeback writeback_i (
    .clk, .rst_i, .start_i(start), .res_valid_i(res_valid), .res_ready_o(res_ready),
    .res_data_i(res_data), .res_addr_i(res_addr), .rd_err_i(res_rd_err),
    .aw_valid_o, .aw_ready_i, .aw_addr_o, .w_valid_o, .w_ready_i, .w_data_o, .w_strb_o,
    .b_valid_i, .b_ready_o, .b_resp_i, .busy_o
  );

endmodule

//--- rtl/tile_fetch.sv
/*
  Fetch stage. Reads the length word at the base address, then the operand
  words one at a time. One read outstanding at most, and a new read is only
  issued while the operand register is empty, so reads stall behind the MAC.
  A failed length read is treated as a zero-length job.
*/
`timescale 1ns/10ps

module tile_fetch (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  tile_axi_pkg::addr_t    base_addr_i,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output tile_axi_pkg::addr_t    ar_addr_o,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  tile_axi_pkg::data_t    r_data_i,
  input  tile_axi_pkg::resp_e    r_resp_i,
  output logic                   op_valid_o,
  input  logic                   op_ready_i,
  output tile_dot_pkg::operand_u op_data_o,
  output logic                   op_last_o,
  output tile_axi_pkg::addr_t    res_addr_o,
  output logic                   rd_err_o
);

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_LEN_AR = 3'd1;
  localparam logic [2:0] S_LEN_R  = 3'd2;
  localparam logic [2:0] S_OP_AR  = 3'd3;
  localparam logic [2:0] S_OP_R   = 3'd4;

  logic [2:0]             state_q;
  tile_axi_pkg::addr_t    addr_q;      // Next read address
  tile_axi_pkg::data_t    rem_q;       // Operands still to read
  tile_axi_pkg::addr_t    res_addr_q;
  tile_dot_pkg::operand_u op_q;
  logic                   op_valid_q;
  logic                   op_last_q;
  logic                   rd_err_q;    // Sticky over the job
  logic                   r_hs;
  logic                   op_hs;
  logic                   r_bad;
  logic                   len_zero;

  assign r_hs     = r_valid_i && r_ready_o;
  assign op_hs    = op_valid_q && op_ready_i;
  assign r_bad    = tile_axi_pkg::resp_is_err(r_resp_i);
  assign len_zero = r_bad || (r_data_i == '0);

  // Operand reads wait for a free register
  assign ar_valid_o = (state_q == S_LEN_AR) || ((state_q == S_OP_AR) && !op_valid_q);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (state_q == S_LEN_R) || (state_q == S_OP_R);
  assign op_valid_o = op_valid_q;
  assign op_data_o  = op_q;
  assign op_last_o  = op_last_q;
  assign res_addr_o = res_addr_q;
  assign rd_err_o   = rd_err_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= S_IDLE;
      op_valid_q <= 1'b0;
      op_last_q  <= 1'b0;
      rd_err_q   <= 1'b0;
    end else begin
      if (op_hs) op_valid_q <= 1'b0;  // Set below wins on a new beat
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            rd_err_q <= 1'b0;
            state_q  <= S_LEN_AR;
          end
        end
        S_LEN_AR: if (ar_ready_i) state_q <= S_LEN_R;
        S_LEN_R: begin
          if (r_hs) begin
            rd_err_q <= r_bad;
            if (len_zero) begin  // Flush a zero operand as the last item
              op_valid_q <= 1'b1;
              op_last_q  <= 1'b1;
              state_q    <= S_IDLE;
            end else begin
              state_q <= S_OP_AR;
            end
          end
        end
        S_OP_AR: if (ar_valid_o && ar_ready_i) state_q <= S_OP_R;
        S_OP_R: begin
          if (r_hs) begin
            op_valid_q <= 1'b1;
            op_last_q  <= (rem_q == 'd1);
            rd_err_q   <= rd_err_q | r_bad;
            state_q    <= (rem_q == 'd1) ? S_IDLE : S_OP_AR;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Addresses, count and operand payload
  always_ff @(posedge clk) begin
    if ((state_q == S_IDLE) && start_i) begin
      addr_q <= base_addr_i;
    end else if (r_hs) begin
      addr_q <= addr_q + 'd4;
    end
    if (r_hs && (state_q == S_LEN_R)) begin
      rem_q      <= r_data_i;
      op_q.raw   <= '0;
      res_addr_q <= len_zero ? addr_q + 'd4 : addr_q + (r_data_i << 2) + 'd4;  // addr_q is base
    end else if (r_hs) begin
      rem_q    <= rem_q - 'd1;
      op_q.raw <= r_data_i;
    end
  end

  // AR request must not move before the handshake
  a_ar_stable: assert property (@(posedge clk) disable iff (rst_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

endmodule

//--- rtl/tile_mac.sv
/*
  MAC stage. One operand pair per cycle, signed 16x16 products summed into
  a 32-bit accumulator that wraps. The result is registered one cycle after
  the last item and held until writeback takes it. No new items are taken
  while a result is pending.
*/
`timescale 1ns/10ps

module tile_mac (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   op_valid_i,
  output logic                   op_ready_o,
  input  tile_dot_pkg::operand_u op_data_i,
  input  logic                   op_last_i,
  input  tile_axi_pkg::addr_t    res_addr_i,
  input  logic                   rd_err_i,
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output tile_dot_pkg::acc_t     res_data_o,
  output tile_axi_pkg::addr_t    res_addr_o,
  output logic                   rd_err_o
);

  tile_dot_pkg::acc_t  acc_q;
  tile_dot_pkg::acc_t  prod;
  tile_dot_pkg::acc_t  sum;
  tile_dot_pkg::acc_t  res_q;
  tile_axi_pkg::addr_t res_addr_q;
  logic                res_valid_q;
  logic                rd_err_q;
  logic                op_hs;

  assign op_ready_o = !res_valid_q;  // Stall while a result waits
  assign op_hs      = op_valid_i && op_ready_o;

  // Both halves signed, so the product is sign extended to 32 bits
  assign prod = op_data_i.pair.op_a * op_data_i.pair.op_b;
  assign sum  = acc_q + prod;  // Wraps on overflow

  always_ff @(posedge clk) begin
    if (rst_i) begin
      acc_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (res_valid_q && res_ready_i) res_valid_q <= 1'b0;
      if (op_hs) begin
        if (op_last_i) begin
          acc_q       <= '0;  // Clean start for the next job
          res_valid_q <= 1'b1;
        end else begin
          acc_q <= sum;
        end
      end
    end
  end

  // Result payload captured with the last item
  always_ff @(posedge clk) begin
    if (op_hs && op_last_i) begin
      res_q      <= sum;
      res_addr_q <= res_addr_i;
      rd_err_q   <= rd_err_i;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_data_o  = res_q;
  assign res_addr_o  = res_addr_q;
  assign rd_err_o    = rd_err_q;

  // Result is offered until writeback accepts it, unchanged
  a_res_hold: assert property (@(posedge clk) disable iff (rst_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_data_o));

endmodule

//--- rtl/tile_writeback.sv
/*
  Writeback stage. Writes the sum to the result address, then the exit code
  to the EOC address. aw and w are raised together and retire on their own.
  The exit code is an error if any read failed or the first write was not
  OKAY. busy_o covers start up to the second write response.
*/
`timescale 1ns/10ps
`include "tile_config.svh"

module tile_writeback (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                start_i,
  input  logic                res_valid_i,
  output logic                res_ready_o,
  input  tile_dot_pkg::acc_t  res_data_i,
  input  tile_axi_pkg::addr_t res_addr_i,
  input  logic                rd_err_i,
  output logic                aw_valid_o,
  input  logic                aw_ready_i,
  output tile_axi_pkg::addr_t aw_addr_o,
  output logic                w_valid_o,
  input  logic                w_ready_i,
  output tile_axi_pkg::data_t w_data_o,
  output tile_axi_pkg::strb_t w_strb_o,
  input  logic                b_valid_i,
  output logic                b_ready_o,
  input  tile_axi_pkg::resp_e b_resp_i,
  output logic                busy_o
);

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_WAIT_RES = 3'd1;
  localparam logic [2:0] S_RES_WR   = 3'd2;
  localparam logic [2:0] S_RES_B    = 3'd3;
  localparam logic [2:0] S_EOC_WR   = 3'd4;
  localparam logic [2:0] S_EOC_B    = 3'd5;

  logic [2:0]          state_q;
  logic                busy_q;
  logic                aw_pend_q;  // aw not yet accepted
  logic                w_pend_q;   // w not yet accepted
  logic                err_q;
  tile_axi_pkg::addr_t aw_addr_q;
  tile_axi_pkg::data_t w_data_q;
  logic                aw_hs;
  logic                w_hs;
  logic                wr_done;
  logic                res_hs;
  logic                b_hs;
  logic                exit_err;

  assign aw_hs    = aw_pend_q && aw_ready_i;
  assign w_hs     = w_pend_q && w_ready_i;
  assign wr_done  = (!aw_pend_q || aw_hs) && (!w_pend_q || w_hs);  // Both sides retired
  assign res_hs   = res_valid_i && res_ready_o;
  assign b_hs     = b_valid_i && b_ready_o;
  assign exit_err = err_q || tile_axi_pkg::resp_is_err(b_resp_i);

  assign res_ready_o = (state_q == S_WAIT_RES);
  assign b_ready_o   = (state_q == S_RES_B) || (state_q == S_EOC_B);
  assign aw_valid_o  = aw_pend_q;
  assign aw_addr_o   = aw_addr_q;
  assign w_valid_o   = w_pend_q;
  assign w_data_o    = w_data_q;
  assign w_strb_o    = '1;  // Full words only
  assign busy_o      = busy_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= S_IDLE;
      busy_q    <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      if (aw_hs) aw_pend_q <= 1'b0;
      if (w_hs) w_pend_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            busy_q  <= 1'b1;
            state_q <= S_WAIT_RES;
          end
        end
        S_WAIT_RES: begin
          if (res_hs) begin
            err_q     <= rd_err_i;
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
            state_q   <= S_RES_WR;
          end
        end
        S_RES_WR: if (wr_done) state_q <= S_RES_B;
        S_RES_B: begin
          if (b_hs) begin  // Result acked, go for the exit code
            err_q     <= exit_err;
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
            state_q   <= S_EOC_WR;
          end
        end
        S_EOC_WR: if (wr_done) state_q <= S_EOC_B;
        S_EOC_B: begin
          if (b_hs) begin
            busy_q  <= 1'b0;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Write payload, address and data for both writes
  always_ff @(posedge clk) begin
    if (res_hs) begin
      aw_addr_q <= res_addr_i;
      w_data_q  <= res_data_i;
    end else if (b_hs && (state_q == S_RES_B)) begin
      aw_addr_q <= `TILE_EOC_ADDR;
      w_data_q  <= exit_err ? `TILE_EXIT_ERR : `TILE_EXIT_OK;
    end
  end

  // No write data outside a job
  a_w_in_job: assert property (@(posedge clk) disable iff (rst_i)
    $rose(w_valid_o) |-> busy_o);

endmodule

//--- sim/tb_dot_tile.sv
/*
  Directed tests for the dot-product tile. Each job is preloaded into the
  VIP memory, started with a fetch_enable edge and checked once busy falls.
  Expected sums follow the signed 16-bit pair rule with 32-bit wrap.
  The run stops at the first mismatch.
*/
`timescale 1ns/10ps
`include "tile_config.svh"

module tb_dot_tile;

  localparam int CLK_PERIOD = 40;
  // Length, operand and result words over all jobs
  localparam int JOB_WORDS  = 6 + 2 + 66 + 6 + 5 + 7;
  localparam int TIMEOUT_NS = (JOB_WORDS * 200 + 1000) * CLK_PERIOD;

  logic                clk;
  logic                rst;
  logic                fetch_enable;
  tile_axi_pkg::addr_t boot_addr;
  logic                busy;
  logic                aw_valid;
  logic                aw_ready;
  tile_axi_pkg::addr_t aw_addr;
  logic                w_valid;
  logic                w_ready;
  tile_axi_pkg::data_t w_data;
  tile_axi_pkg::strb_t w_strb;
  logic                b_valid;
  logic                b_ready;
  tile_axi_pkg::resp_e b_resp;
  logic                ar_valid;
  logic                ar_ready;
  tile_axi_pkg::addr_t ar_addr;
  logic                r_valid;
  logic                r_ready;
  tile_axi_pkg::data_t r_data;
  tile_axi_pkg::resp_e r_resp;

  tile_axi_pkg::data_t ops [$];  // Operand words of the job being built
  tile_axi_pkg::data_t rnd_q;

  tile_vip vip_i (
    .clk(clk), .rst_o(rst), .fetch_enable_o(fetch_enable), .boot_addr_o(boot_addr),
    .busy_i(busy), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
    .b_valid_o(b_valid), .b_ready_i(b_ready), .b_resp_o(b_resp),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_resp_o(r_resp)
  );

  dot_tile dot_tile_i (
    .clk(clk), .rst_i(rst), .fetch_enable_i(fetch_enable), .boot_addr_i(boot_addr),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_data_o(w_data), .w_strb_o(w_strb),
    .b_valid_i(b_valid), .b_ready_o(b_ready), .b_resp_i(b_resp),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data), .r_resp_i(r_resp),
    .busy_o(busy)
  );

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare_sum(input tile_dot_pkg::acc_t got, input tile_dot_pkg::acc_t exp,
                             input string what);
    if (got !== exp)
      abort($sformatf("Error at %0d ns: %s sum is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic compare_code(input tile_axi_pkg::data_t got, input tile_axi_pkg::data_t exp,
                              input string what);
    if (got !== exp)
      abort($sformatf("Error at %0d ns: %s exit code is %0d, expected %0d",
                      $time, what, got, exp));
  endtask

  task automatic compare_addr(input tile_axi_pkg::addr_t got, input tile_axi_pkg::addr_t exp,
                              input string what);
    if (got !== exp)
      abort($sformatf("Error at %0d ns: %s result went to %h, expected %h",
                      $time, what, got, exp));
  endtask

  task automatic check_idle(input string what);
    if (busy !== 1'b0) abort($sformatf("busy is high %s although the tile should be idle", what));
  endtask

  // Sum of signed 16-bit op_a * op_b products wrapping at 32 bits
  function automatic tile_dot_pkg::acc_t expected_sum();
    int       acc;
    int       prod;
    shortint  a;
    shortint  b;
    acc = 0;
    foreach (ops[i]) begin
      a    = shortint'(ops[i][31:16]);  // Upper half is op_a
      b    = shortint'(ops[i][15:0]);
      prod = a * b;
      acc  = acc + prod;
    end
    return acc;
  endfunction

  // err_idx < 0 means no injected error, and the sum is checked
  task automatic run_job(input tile_axi_pkg::addr_t base, input int err_idx,
                         input tile_axi_pkg::data_t exp_code, input string what);
    tile_axi_pkg::addr_t res_addr;
    string               fault;
    res_addr = base + 4 * ops.size() + 4;  // Word after the last operand
    vip_i.preload(base, ops.size());
    foreach (ops[i]) vip_i.preload(base + 4 * (i + 1), ops[i]);
    vip_i.preload(res_addr, 32'hA5A5_0000 ^ res_addr);  // Stale value that is never a valid sum here
    vip_i.init(base);
    check_idle($sformatf("before the %s", what));  // One cycle on from the last job or reset
    if (err_idx >= 0) vip_i.inject_error(base + 4 * (err_idx + 1));
    vip_i.run();
    vip_i.wait_for_eoc(fault);
    if (fault != "") abort($sformatf("The %s did not complete: %s", what, fault));
    compare_code(vip_i.peek(`TILE_EOC_ADDR), exp_code, what);
    compare_addr(vip_i.last_wr_addr, res_addr, what);
    if (err_idx < 0) compare_sum(vip_i.peek(res_addr), expected_sum(), what);
  endtask

  task automatic test_small_job();
    ops.delete();
    ops.push_back(32'h0003_0004);  // 3 * 4
    ops.push_back(32'hFFFE_0005);  // -2 * 5
    ops.push_back(32'h0007_FFF9);  // 7 * -7
    ops.push_back(32'hFFFF_FFFF);  // -1 * -1
    run_job(32'h0000_0100, -1, `TILE_EXIT_OK, "small job");
  endtask

  task automatic test_zero_length();
    ops.delete();
    run_job(32'h0000_0200, -1, `TILE_EXIT_OK, "zero-length job");
  endtask

  task automatic test_wrap();
    ops.delete();
    repeat (4) ops.push_back(32'h8000_8000);  // Four times 2**30 wraps the sum
    ops.push_back(32'h7FFF_8000);
    ops.push_back(32'h7FFF_7FFF);
    while (ops.size() < 64) begin
      rnd_q = vip_i.xorshift32(rnd_q);
      ops.push_back(rnd_q);
    end
    run_job(32'h0000_0400, -1, `TILE_EXIT_OK, "wrap-around job");
  endtask

  task automatic test_read_error();
    ops.delete();
    ops.push_back(32'h0001_0001);
    ops.push_back(32'h0002_0002);
    ops.push_back(32'h0003_0003);
    ops.push_back(32'h0004_0004);
    run_job(32'h0000_0800, 2, `TILE_EXIT_ERR, "read-error job");  // Third operand fails
  endtask

  task automatic test_back_to_back();
    ops.delete();
    ops.push_back(32'h0010_FFF0);
    ops.push_back(32'hFF00_0100);
    ops.push_back(32'h1234_0002);
    run_job(32'h0000_0A00, -1, `TILE_EXIT_OK, "first back-to-back job");
    ops.delete();
    ops.push_back(32'h7FFF_0002);
    ops.push_back(32'h8000_0001);
    ops.push_back(32'h0005_0005);
    ops.push_back(32'hFFFB_0005);
    ops.push_back(32'h0100_0100);
    run_job(32'h0000_0C00, -1, `TILE_EXIT_OK, "second back-to-back job");
  endtask

  initial begin
    rnd_q = 32'h5ece;
    @(negedge clk);
    while (rst) @(negedge clk);
    check_idle("after reset");
    test_small_job();
    test_zero_length();
    test_wrap();
    test_read_error();
    test_back_to_back();
    $display("all tests passed");
    $finish;
  end

  // Watchdog allows 200 cycles per word plus margin
  initial begin : watchdog
    #(TIMEOUT_NS);
    abort($sformatf("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS));
  end

endmodule

//--- sim/tile_vip.sv
/*
  Simulation VIP for the dot-product tile. Generates clk and rst_o, drives
  boot_addr_o and fetch_enable_o, and models an AXI4-Lite memory of 4096 words
  at address 0 plus the EOC word. Each channel pair takes one transaction at a
  time and answers after 0 to 3 random cycles. Other addresses get DECERR.
  Outputs change on the falling clock edge.
*/
`timescale 1ns/10ps
`include "tile_config.svh"

module tile_vip (
  output logic                clk,
  output logic                rst_o,
  output logic                fetch_enable_o,
  output tile_axi_pkg::addr_t boot_addr_o,
  input  logic                busy_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  tile_axi_pkg::addr_t aw_addr_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  tile_axi_pkg::data_t w_data_i,
  input  tile_axi_pkg::strb_t w_strb_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output tile_axi_pkg::resp_e b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  tile_axi_pkg::addr_t ar_addr_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output tile_axi_pkg::data_t r_data_o,
  output tile_axi_pkg::resp_e r_resp_o
);

  localparam int MEM_WORDS   = 4096;  // Word index is addr[13:2]
  localparam int HALF_PERIOD = 20;

  tile_axi_pkg::data_t mem [MEM_WORDS];
  tile_axi_pkg::data_t eoc_q;         // Exit code word
  tile_axi_pkg::addr_t err_addr_q;    // SLVERR target
  logic                err_en_q;
  tile_axi_pkg::addr_t last_wr_addr;  // Last write that missed the EOC word

  always begin
    clk = 1'b0;
    #HALF_PERIOD;
    clk = 1'b1;
    #HALF_PERIOD;
  end

  function automatic tile_axi_pkg::data_t xorshift32(input tile_axi_pkg::data_t x);
    tile_axi_pkg::data_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Response for one address
  function automatic tile_axi_pkg::resp_e decode(input tile_axi_pkg::addr_t a);
    if (err_en_q && (a == err_addr_q)) return tile_axi_pkg::SLVERR;
    if ((a == `TILE_EOC_ADDR) || (a < MEM_WORDS * 4)) return tile_axi_pkg::OKAY;
    return tile_axi_pkg::DECERR;
  endfunction

  function automatic tile_axi_pkg::data_t peek(input tile_axi_pkg::addr_t a);
    if (a == `TILE_EOC_ADDR) return eoc_q;
    return mem[a[13:2]];
  endfunction

  task automatic store(input tile_axi_pkg::addr_t a, input tile_axi_pkg::data_t d,
                       input tile_axi_pkg::strb_t s);
    if (a == `TILE_EOC_ADDR) begin
      eoc_q = d;
    end else begin
      last_wr_addr = a;
      for (int i = 0; i < 4; i++) begin
        if (s[i]) mem[a[13:2]][8*i +: 8] = d[8*i +: 8];  // Byte lanes
      end
    end
  endtask

  // 0 to 3 falling edges
  task automatic wait_random(inout tile_axi_pkg::data_t state);
    state = xorshift32(state);
    repeat (state[1:0]) @(negedge clk);
  endtask

  task automatic preload(input tile_axi_pkg::addr_t a, input tile_axi_pkg::data_t d);
    mem[a[13:2]] = d;
  endtask

  // New job: clears the exit code and error injection, fetch_enable low
  task automatic init(input tile_axi_pkg::addr_t boot);
    @(negedge clk);
    boot_addr_o    = boot;
    fetch_enable_o = 1'b0;
    eoc_q          = '0;
    err_en_q       = 1'b0;
  endtask

  task automatic inject_error(input tile_axi_pkg::addr_t a);
    err_addr_q = a;
    err_en_q   = 1'b1;
  endtask

  task automatic run();
    @(negedge clk);
    fetch_enable_o = 1'b1;  // Edge starts the job
  endtask

  // Empty fault string when the job ran and left an exit code
  task automatic wait_for_eoc(output string fault);
    fault = "";
    @(negedge clk);
    if (!busy_i) fault = "busy did not rise after fetch_enable";
    while (busy_i) @(negedge clk);
    if ((fault == "") && (eoc_q == '0)) fault = "no exit code was written";
  endtask

  initial begin
    rst_o          = 1'b1;
    fetch_enable_o = 1'b0;
    boot_addr_o    = '0;
    eoc_q          = '0;
    err_en_q       = 1'b0;
    err_addr_q     = '0;
    last_wr_addr   = '0;
    foreach (mem[i]) mem[i] = '0;
    repeat (10) @(negedge clk);
    rst_o = 1'b0;
  end

  initial begin : read_channel
    tile_axi_pkg::addr_t addr;
    tile_axi_pkg::data_t rnd;
    rnd        = 32'h5ece;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = tile_axi_pkg::OKAY;
    forever begin
      @(negedge clk);
      if (!rst_o && ar_valid_i) begin
        wait_random(rnd);
        addr       = ar_addr_i;
        ar_ready_o = 1'b1;  // Valid is held, next edge takes it
        @(negedge clk);
        ar_ready_o = 1'b0;
        wait_random(rnd);
        r_resp_o  = decode(addr);
        r_data_o  = (r_resp_o == tile_axi_pkg::OKAY) ? peek(addr) : '0;
        r_valid_o = 1'b1;
        while (!r_ready_i) @(negedge clk);
        @(negedge clk);
        r_valid_o = 1'b0;
      end
    end
  end

  initial begin : write_channel
    tile_axi_pkg::addr_t addr;
    tile_axi_pkg::data_t data;
    tile_axi_pkg::strb_t strb;
    tile_axi_pkg::data_t rnd;
    rnd        = xorshift32(32'h5ece);  // Own stream, off the read one
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    b_resp_o   = tile_axi_pkg::OKAY;
    forever begin
      @(negedge clk);
      if (!rst_o && aw_valid_i && w_valid_i) begin  // Tile raises both together
        wait_random(rnd);
        addr       = aw_addr_i;
        data       = w_data_i;
        strb       = w_strb_i;
        aw_ready_o = 1'b1;
        w_ready_o  = 1'b1;
        @(negedge clk);
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_resp_o   = decode(addr);
        if (b_resp_o == tile_axi_pkg::OKAY) store(addr, data, strb);
        wait_random(rnd);
        b_valid_o = 1'b1;
        while (!b_ready_i) @(negedge clk);
        @(negedge clk);
        b_valid_o = 1'b0;
      end
    end
  end

endmodule

//--- verilog.f
+incdir+common
common/tile_axi_pkg.sv
common/tile_dot_pkg.sv
rtl/tile_fetch.sv
rtl/tile_mac.sv
rtl/tile_writeback.sv
rtl/dot_tile.sv
sim/tile_vip.sv
sim/tb_dot_tile.sv
